//--- Makefile
# Verilator build and run of the packet traffic testbench

TOP = pktgen_tb
LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove build output and the log"

test:
	verilator --binary --timing --assert -Wno-fatal -f project.f \
		--top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "Verification passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- design/pkt_fifo.sv
/* Store-and-forward packet FIFO
   Beats are readable only once their packet's last beat is stored */

`timescale 1ns/100ps
`default_nettype none

`include "pktgen_defines.svh"

module pkt_fifo (
    input  wire                         clk_ifc,
    input  wire                         rst_n,
    input  wire pktgen_pkg::axis_beat_t in_beat,
    input  wire                         in_valid,
    output logic                        in_ready,
    output pktgen_pkg::axis_beat_t      out_beat,
    output logic                        out_valid,
    input  wire                         out_ready
);

    localparam int AW = $clog2(`PKT_FIFO_DEPTH);

    pktgen_pkg::axis_beat_t mem [`PKT_FIFO_DEPTH];

    // Pointers carry one wrap bit
    logic [AW:0] wr_ptr;
    logic [AW:0] commit_ptr;
    logic [AW:0] rd_ptr;
    logic        wr_en;
    logic        rd_en;

    assign in_ready = !((wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]));
    assign wr_en    = in_valid && in_ready;
    // Refill the output register from committed beats only
    assign rd_en    = (rd_ptr != commit_ptr) && (!out_valid || out_ready);

    always_ff @(posedge clk_ifc) begin
        if (!rst_n) begin
            wr_ptr     <= '0;
            commit_ptr <= '0;
            rd_ptr     <= '0;
            out_valid  <= 1'b0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
                if (in_beat.last) begin
                    commit_ptr <= wr_ptr + 1'b1;
                end
            end
            if (rd_en) begin
                rd_ptr    <= rd_ptr + 1'b1;
                out_valid <= 1'b1;
            end else if (out_ready) begin
                out_valid <= 1'b0;
            end
        end
    end

    //////////////////////////////////////////////////
    // Beat storage and output register

    always_ff @(posedge clk_ifc) begin
        if (wr_en) begin
            mem[wr_ptr[AW-1:0]] <= in_beat;
        end
        if (rd_en) begin
            out_beat <= mem[rd_ptr[AW-1:0]];
        end
    end

endmodule

`default_nettype wire

//--- design/pkt_sink.sv
/* Packet sink
   Checks sequence, length and LFSR payload, and counts good and bad packets */

`timescale 1ns/100ps
`default_nettype none

module pkt_sink (
    input  wire                         clk_ifc,
    input  wire                         rst_n,
    input  wire [31:0]                  seed,
    input  wire pktgen_pkg::axis_beat_t in_beat,
    input  wire                         in_valid,
    output logic                        in_ready,
    output logic [15:0]                 good,
    output logic [15:0]                 bad
);

    logic        in_pkt;
    logic [15:0] exp_seq;
    logic [31:0] lfsr;
    logic [15:0] remaining;
    logic        err;

    logic        xfer;
    logic        hdr_phase;
    logic        restart;
    logic [15:0] seq_exp;
    logic [31:0] hdr_lfsr;
    logic [31:0] pay_lfsr;
    logic        beat_err;
    logic        done;
    logic        pkt_bad;

    assign in_ready = 1'b1;
    assign xfer     = in_valid && in_ready;
    assign hdr_phase = !in_pkt;

    // Sequence 0 marks the first packet of a new run
    assign restart  = xfer && hdr_phase && (in_beat.data.hdr.seq == 16'd0);
    assign seq_exp  = restart ? 16'd0 : exp_seq;
    assign hdr_lfsr = pktgen_pkg::lfsr_next(seed ^ {16'h0, seq_exp});
    assign pay_lfsr = pktgen_pkg::lfsr_next(lfsr);

    always_comb begin
        if (hdr_phase) begin
            // A header with last set must announce no payload
            beat_err = (in_beat.data.hdr.seq != seq_exp) ||
                       (in_beat.last && in_beat.data.hdr.len != 16'd0);
        end else begin
            beat_err = (in_beat.data.raw != pay_lfsr) ||
                       (in_beat.last != (remaining == 16'd1));
        end
    end

    assign done    = xfer && in_beat.last;
    assign pkt_bad = (!hdr_phase && err) || beat_err;

    always_ff @(posedge clk_ifc) begin
        if (!rst_n) begin
            in_pkt  <= 1'b0;
            exp_seq <= '0;
            err     <= 1'b0;
            good    <= '0;
            bad     <= '0;
        end else if (xfer) begin
            in_pkt <= !in_beat.last;
            err    <= pkt_bad;
            if (hdr_phase) begin
                exp_seq <= seq_exp + 16'd1;
            end
            good <= (restart ? 16'd0 : good) + 16'(done && !pkt_bad);
            bad  <= (restart ? 16'd0 : bad) + 16'(done && pkt_bad);
        end
    end

    //////////////////////////////////////////////////
    // Expected payload state

    always_ff @(posedge clk_ifc) begin
        if (xfer) begin
            if (hdr_phase) begin
                lfsr      <= hdr_lfsr;
                remaining <= in_beat.data.hdr.len;
            end else begin
                lfsr      <= pay_lfsr;
                remaining <= remaining - 16'd1;
            end
        end
    end

endmodule

`default_nettype wire

//--- design/pkt_source.sv
/* Packet source
   Sends a header beat then LFSR payload beats, packet after packet */

`timescale 1ns/100ps
`default_nettype none

module pkt_source (
    input  wire                          clk_ifc,
    input  wire                          rst_n,
    input  wire pktgen_pkg::pktgen_cfg_t cfg,
    input  wire                          start,
    input  wire                          inject,
    output pktgen_pkg::axis_beat_t       out_beat,
    output logic                         out_valid,
    input  wire                          out_ready,
    output logic                         busy,
    output logic [15:0]                  sent
);

    logic [15:0] seq;
    logic [31:0] lfsr;
    // Payload beats still to load after the current beat
    logic [15:0] remaining;
    logic        inject_pend;
    logic        inject_cur;

    logic        xfer;
    logic [15:0] hdr_seq;
    logic [31:0] hdr_lfsr;
    logic [15:0] hdr_len;
    logic [31:0] pay_lfsr;

    assign xfer = out_valid && out_ready;

    // Next header is packet 0 on start, else the following packet
    assign hdr_seq  = busy ? seq + 16'd1 : 16'd0;
    assign hdr_lfsr = pktgen_pkg::lfsr_next(cfg.seed ^ {16'h0, hdr_seq});
    assign hdr_len  = {10'h0, cfg.min_len} + {10'h0, hdr_lfsr[5:0] & cfg.len_mask};
    assign pay_lfsr = pktgen_pkg::lfsr_next(lfsr);

    always_ff @(posedge clk_ifc) begin
        if (!rst_n) begin
            busy        <= 1'b0;
            out_valid   <= 1'b0;
            seq         <= '0;
            sent        <= '0;
            inject_pend <= 1'b0;
            inject_cur  <= 1'b0;
        end else begin
            if (inject) begin
                inject_pend <= 1'b1;
            end
            if (!busy) begin
                if (start && cfg.count != 16'd0) begin
                    busy        <= 1'b1;
                    sent        <= '0;
                    out_valid   <= 1'b1;
                    seq         <= hdr_seq;
                    inject_cur  <= inject_pend || inject;
                    inject_pend <= 1'b0;
                end
            end else if (xfer) begin
                if (out_beat.last) begin
                    sent <= sent + 16'd1;
                    if (seq + 16'd1 == cfg.count) begin
                        busy      <= 1'b0;
                        out_valid <= 1'b0;
                    end else begin
                        seq         <= hdr_seq;
                        inject_cur  <= inject_pend || inject;
                        inject_pend <= 1'b0;
                    end
                end
            end
        end
    end

    //////////////////////////////////////////////////
    // Beat payload, held while the FIFO stalls

    always_ff @(posedge clk_ifc) begin
        if ((!busy && start) || (xfer && out_beat.last)) begin
            lfsr                  <= hdr_lfsr;
            remaining             <= hdr_len;
            out_beat.data.hdr.seq <= hdr_seq;
            out_beat.data.hdr.len <= hdr_len;
            out_beat.last         <= (hdr_len == 16'd0);
        end else if (xfer) begin
            lfsr      <= pay_lfsr;
            remaining <= remaining - 16'd1;
            // Inject flips bit 0 of the final payload word
            out_beat.data.raw <= pay_lfsr ^ {31'h0, inject_cur && remaining == 16'd1};
            out_beat.last     <= (remaining == 16'd1);
        end
    end

endmodule

`default_nettype wire

//--- design/pktgen_defines.svh
/* Packet traffic subsystem parameters
   Stream width, FIFO depth, LFSR taps and register map */

`ifndef PKTGEN_DEFINES_SVH
`define PKTGEN_DEFINES_SVH

// Stream word and FIFO sizing
`define PKT_DATA_W      32
`define PKT_FIFO_DEPTH  128

// Galois LFSR tap mask
`define PKT_LFSR_POLY   32'h8020_0003

// AXI4-Lite address width
`define PKT_AXIL_ADDR_W 8

// Register byte offsets
`define PKT_REG_CTRL    8'h00
`define PKT_REG_SEED    8'h04
`define PKT_REG_COUNT   8'h08
`define PKT_REG_LEN     8'h0C
`define PKT_REG_STATUS  8'h10
`define PKT_REG_SENT    8'h14
`define PKT_REG_GOOD    8'h18
`define PKT_REG_BAD     8'h1C

`endif

//--- design/pktgen_pkg.sv
/* Packet traffic subsystem types
   Beat word views, stream beat, config, status and AXI4-Lite channels */

`default_nettype none

`include "pktgen_defines.svh"

package pktgen_pkg;

    // Header view, one word
    typedef struct packed {
        logic [15:0] seq;
        logic [15:0] len;
    } pkt_hdr_t;

    // Beat word is either a header or a raw payload word
    typedef union packed {
        logic [`PKT_DATA_W-1:0] raw;
        pkt_hdr_t               hdr;
    } pkt_word_u;

    typedef struct packed {
        pkt_word_u data;
        logic      last;
    } axis_beat_t;

    typedef struct packed {
        logic [31:0] seed;
        logic [15:0] count;
        logic [5:0]  min_len;
        logic [5:0]  len_mask;
    } pktgen_cfg_t;

    typedef struct packed {
        logic [15:0] sent;
        logic [15:0] good;
        logic [15:0] bad;
    } pktgen_stat_t;

    typedef struct packed {
        logic [`PKT_AXIL_ADDR_W-1:0] awaddr;
        logic                        awvalid;
        logic [31:0]                 wdata;
        logic                        wvalid;
        logic                        bready;
        logic [`PKT_AXIL_ADDR_W-1:0] araddr;
        logic                        arvalid;
        logic                        rready;
    } axil_req_t;

    typedef struct packed {
        logic        awready;
        logic        wready;
        logic [1:0]  bresp;
        logic        bvalid;
        logic        arready;
        logic [31:0] rdata;
        logic [1:0]  rresp;
        logic        rvalid;
    } axil_rsp_t;

    // One LFSR step, shared by generator and checker
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        logic [31:0] shifted;
        shifted = state >> 1;
        return state[0] ? (shifted ^ `PKT_LFSR_POLY) : shifted;
    endfunction

endpackage

`default_nettype wire

//--- design/pktgen_regs.sv
/* Packet traffic register block
   AXI4-Lite slave for config, start and inject pulses, and status */

`timescale 1ns/100ps
`default_nettype none

`include "pktgen_defines.svh"

module pktgen_regs (
    input  wire                           clk_ifc,
    input  wire                           rst_n,
    input  wire pktgen_pkg::axil_req_t    axil_req,
    output pktgen_pkg::axil_rsp_t         axil_rsp,
    output pktgen_pkg::pktgen_cfg_t       cfg,
    output logic                          start,
    output logic                          inject,
    input  wire                           busy,
    input  wire pktgen_pkg::pktgen_stat_t stat
);

    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    logic        aw_rdy;
    logic        b_valid;
    logic [1:0]  b_resp;
    logic        ar_rdy;
    logic        r_valid;
    logic [1:0]  r_resp;
    logic [31:0] r_data;

    logic        wr_en;
    logic        rd_en;
    logic        wr_err;
    logic        rd_err;
    logic [31:0] rd_word;

    assign wr_en = aw_rdy && axil_req.awvalid && axil_req.wvalid;
    assign rd_en = ar_rdy && axil_req.arvalid;

    assign axil_rsp = '{
        awready: aw_rdy,
        wready:  aw_rdy,
        bresp:   b_resp,
        bvalid:  b_valid,
        arready: ar_rdy,
        rdata:   r_data,
        rresp:   r_resp,
        rvalid:  r_valid
    };

    //////////////////////////////////////////////////
    // Address decode

    // Only CTRL, SEED, COUNT and LEN are writable
    always_comb begin
        case (axil_req.awaddr)
            `PKT_REG_CTRL, `PKT_REG_SEED, `PKT_REG_COUNT, `PKT_REG_LEN: wr_err = 1'b0;
            default: wr_err = 1'b1;
        endcase
    end

    always_comb begin
        rd_err  = 1'b0;
        rd_word = '0;
        case (axil_req.araddr)
            `PKT_REG_CTRL:   rd_word = '0;
            `PKT_REG_SEED:   rd_word = cfg.seed;
            `PKT_REG_COUNT:  rd_word = {16'h0, cfg.count};
            `PKT_REG_LEN:    rd_word = {18'h0, cfg.len_mask, 2'b00, cfg.min_len};
            `PKT_REG_STATUS: rd_word = {31'h0, busy};
            `PKT_REG_SENT:   rd_word = {16'h0, stat.sent};
            `PKT_REG_GOOD:   rd_word = {16'h0, stat.good};
            `PKT_REG_BAD:    rd_word = {16'h0, stat.bad};
            default:         rd_err = 1'b1;
        endcase
    end

    //////////////////////////////////////////////////
    // Write channel and config registers

    always_ff @(posedge clk_ifc) begin
        if (!rst_n) begin
            aw_rdy  <= 1'b0;
            b_valid <= 1'b0;
            b_resp  <= RESP_OKAY;
            start   <= 1'b0;
            inject  <= 1'b0;
            cfg     <= '0;
        end else begin
            start  <= 1'b0;
            inject <= 1'b0;
            // One cycle of ready once both address and data are offered
            aw_rdy <= axil_req.awvalid && axil_req.wvalid && !aw_rdy && !b_valid;
            if (wr_en) begin
                b_valid <= 1'b1;
                b_resp  <= wr_err ? RESP_SLVERR : RESP_OKAY;
                case (axil_req.awaddr)
                    `PKT_REG_CTRL: begin
                        // A start during a run is dropped
                        start  <= axil_req.wdata[0] && !busy;
                        inject <= axil_req.wdata[1];
                    end
                    `PKT_REG_SEED:  cfg.seed  <= axil_req.wdata;
                    `PKT_REG_COUNT: cfg.count <= axil_req.wdata[15:0];
                    `PKT_REG_LEN: begin
                        cfg.min_len  <= axil_req.wdata[5:0];
                        cfg.len_mask <= axil_req.wdata[13:8];
                    end
                    default: ;
                endcase
            end else if (b_valid && axil_req.bready) begin
                b_valid <= 1'b0;
            end
        end
    end

    //////////////////////////////////////////////////
    // Read channel

    always_ff @(posedge clk_ifc) begin
        if (!rst_n) begin
            ar_rdy  <= 1'b0;
            r_valid <= 1'b0;
            r_resp  <= RESP_OKAY;
        end else begin
            ar_rdy <= axil_req.arvalid && !ar_rdy && !r_valid;
            if (rd_en) begin
                r_valid <= 1'b1;
                r_resp  <= rd_err ? RESP_SLVERR : RESP_OKAY;
            end else if (r_valid && axil_req.rready) begin
                r_valid <= 1'b0;
            end
        end
    end

    // Read data captured at the address handshake
    always_ff @(posedge clk_ifc) begin
        if (rd_en) begin
            r_data <= rd_word;
        end
    end

endmodule

`default_nettype wire

//--- design/pktgen_top.sv
/* Packet traffic subsystem top
   Register block, packet source, packet FIFO and packet sink */

`timescale 1ns/100ps
`default_nettype none

module pktgen_top (
    input  wire                        clk_ifc,
    input  wire                        rst_n,
    input  wire pktgen_pkg::axil_req_t axil_req,
    output pktgen_pkg::axil_rsp_t      axil_rsp
);

    pktgen_pkg::pktgen_cfg_t  cfg;
    pktgen_pkg::pktgen_stat_t stat;
    logic                     start;
    logic                     inject;
    logic                     busy;

    // Source to FIFO hop
    pktgen_pkg::axis_beat_t   src_beat;
    logic                     src_valid;
    logic                     src_ready;

    // FIFO to sink hop
    pktgen_pkg::axis_beat_t   snk_beat;
    logic                     snk_valid;
    logic                     snk_ready;

    pktgen_regs i_pktgen_regs (
        .clk_ifc  (clk_ifc),
        .rst_n    (rst_n),
        .axil_req (axil_req),
        .axil_rsp (axil_rsp),
        .cfg      (cfg),
        .start    (start),
        .inject   (inject),
        .busy     (busy),
        .stat     (stat)
    );

    pkt_source i_pkt_source (
        .clk_ifc   (clk_ifc),
        .rst_n     (rst_n),
        .cfg       (cfg),
        .start     (start),
        .inject    (inject),
        .out_beat  (src_beat),
        .out_valid (src_valid),
        .out_ready (src_ready),
        .busy      (busy),
        .sent      (stat.sent)
    );

    pkt_fifo i_pkt_fifo (
        .clk_ifc   (clk_ifc),
        .rst_n     (rst_n),
        .in_beat   (src_beat),
        .in_valid  (src_valid),
        .in_ready  (src_ready),
        .out_beat  (snk_beat),
        .out_valid (snk_valid),
        .out_ready (snk_ready)
    );

    pkt_sink i_pkt_sink (
        .clk_ifc  (clk_ifc),
        .rst_n    (rst_n),
        .seed     (cfg.seed),
        .in_beat  (snk_beat),
        .in_valid (snk_valid),
        .in_ready (snk_ready),
        .good     (stat.good),
        .bad      (stat.bad)
    );

endmodule

`default_nettype wire

//--- project.f
+incdir+design
design/pktgen_pkg.sv
design/pktgen_regs.sv
design/pkt_source.sv
design/pkt_fifo.sv
design/pkt_sink.sv
design/pktgen_top.sv
testbench/pktgen_props.sv
testbench/pktgen_tb.sv

//--- testbench/pktgen_props.sv
/* Stream and AXI4-Lite handshake properties
   Bound into the packet FIFO and the register block */

`timescale 1ns/100ps
`default_nettype none

module pktgen_props (
    input wire                         clk_ifc,
    input wire                         rst_n,
    input wire pktgen_pkg::axis_beat_t in_beat,
    input wire                         in_valid,
    input wire                         in_ready,
    input wire pktgen_pkg::axis_beat_t out_beat,
    input wire                         out_valid,
    input wire                         out_ready,
    input wire                         bvalid,
    input wire                         bready,
    input wire                         rvalid,
    input wire                         rready
);

    // Packets whose last beat is stored but not yet passed on
    logic [15:0] pkts_held;

    always_ff @(posedge clk_ifc) begin
        if (!rst_n) begin
            pkts_held <= '0;
        end else begin
            pkts_held <= pkts_held + 16'(in_valid && in_ready && in_beat.last)
                                   - 16'(out_valid && out_ready && out_beat.last);
        end
    end

    //////////////////////////////////////////////////
    // Stream hops hold their beat until accepted

    in_hold: assert property (@(posedge clk_ifc) disable iff (!rst_n)
        in_valid && !in_ready |=> in_valid && $stable(in_beat))
        else $error("FIFO input beat changed or dropped before ready");

    out_hold: assert property (@(posedge clk_ifc) disable iff (!rst_n)
        out_valid && !out_ready |=> out_valid && $stable(out_beat))
        else $error("FIFO output beat changed or dropped before ready");

    // Any beat on the output belongs to a packet stored in full
    out_committed: assert property (@(posedge clk_ifc) disable iff (!rst_n)
        out_valid |-> pkts_held != 16'd0)
        else $error("FIFO output valid without a committed packet");

    //////////////////////////////////////////////////
    // AXI4-Lite responses

    b_hold: assert property (@(posedge clk_ifc) disable iff (!rst_n)
        bvalid && !bready |=> bvalid)
        else $error("bvalid dropped before bready");

    r_hold: assert property (@(posedge clk_ifc) disable iff (!rst_n)
        rvalid && !rready |=> rvalid)
        else $error("rvalid dropped before rready");

endmodule

bind pkt_fifo pktgen_props i_fifo_props (
    .clk_ifc    (clk_ifc),
    .rst_n      (rst_n),
    .in_beat    (in_beat),
    .in_valid   (in_valid),
    .in_ready   (in_ready),
    .out_beat   (out_beat),
    .out_valid  (out_valid),
    .out_ready  (out_ready),
    .bvalid     (1'b0),
    .bready     (1'b0),
    .rvalid     (1'b0),
    .rready     (1'b0)
);

bind pktgen_regs pktgen_props i_regs_props (
    .clk_ifc    (clk_ifc),
    .rst_n      (rst_n),
    .in_beat    ('0),
    .in_valid   (1'b0),
    .in_ready   (1'b0),
    .out_beat   ('0),
    .out_valid  (1'b0),
    .out_ready  (1'b0),
    .bvalid     (b_valid),
    .bready     (axil_req.bready),
    .rvalid     (r_valid),
    .rready     (axil_req.rready)
);

`default_nettype wire

//--- testbench/pktgen_tb.sv
/* Packet traffic subsystem testbench
   Random register and traffic tests checked against an LFSR model */

`timescale 1ns/100ps
`default_nettype none

`include "pktgen_defines.svh"

module pktgen_tb;

    localparam int CLK_PERIOD = 8;
    localparam int RUNS       = 6;
    localparam int MAX_PKTS   = 20;
    localparam int MAX_LEN    = 126;
    // Worst case beats per run, four cycles each, plus polling margin
    localparam int TIMEOUT_CYCLES = RUNS * MAX_PKTS * (MAX_LEN + 2) * 4 + 5000;
    localparam logic [1:0] OKAY   = 2'b00;
    localparam logic [1:0] SLVERR = 2'b10;

    logic                  clk_ifc;
    logic                  rst_n;
    pktgen_pkg::axil_req_t axil_req;
    pktgen_pkg::axil_rsp_t axil_rsp;

    int errors;
    int tests_run;
    int tests_failed;

    pktgen_top i_pktgen_top (
        .clk_ifc  (clk_ifc),
        .rst_n    (rst_n),
        .axil_req (axil_req),
        .axil_rsp (axil_rsp)
    );

    initial begin
        clk_ifc = 1'b0;
        forever #(CLK_PERIOD / 2) clk_ifc = ~clk_ifc;
    end

    initial begin
        #(TIMEOUT_CYCLES * CLK_PERIOD);
        $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Verification failed");
        $finish;
    end

    //////////////////////////////////////////////////
    // Reference model

    function automatic logic [31:0] model_step(input logic [31:0] state);
        logic [31:0] nxt_state;
        nxt_state = {1'b0, state[31:1]};
        if (state[0]) begin
            nxt_state = nxt_state ^ `PKT_LFSR_POLY;
        end
        return nxt_state;
    endfunction

    // Payload beats of packet seq
    function automatic logic [15:0] model_len(input logic [31:0] seed, input logic [15:0] seq,
                                              input logic [5:0] min_len,
                                              input logic [5:0] len_mask);
        logic [31:0] state;
        state = model_step(seed ^ {16'h0, seq});
        return {10'h0, min_len} + {10'h0, state[5:0] & len_mask};
    endfunction

    //////////////////////////////////////////////////
    // Bus access and checks

    task automatic write_reg(input logic [7:0] addr, input logic [31:0] data,
                             output logic [1:0] resp);
        @(posedge clk_ifc);
        axil_req.awaddr  <= addr;
        axil_req.wdata   <= data;
        axil_req.awvalid <= 1'b1;
        axil_req.wvalid  <= 1'b1;
        @(negedge clk_ifc);
        while (!axil_rsp.awready) @(negedge clk_ifc);
        if (axil_rsp.wready !== 1'b1) begin
            $display("Write data was not accepted together with the write address");
            errors++;
        end
        @(posedge clk_ifc);
        axil_req.awvalid <= 1'b0;
        axil_req.wvalid  <= 1'b0;
        @(negedge clk_ifc);
        while (!axil_rsp.bvalid) @(negedge clk_ifc);
        resp = axil_rsp.bresp;
        // Response is taken after a short random stall
        repeat ($urandom % 3) @(posedge clk_ifc);
        @(posedge clk_ifc);
        axil_req.bready <= 1'b1;
        @(posedge clk_ifc);
        axil_req.bready <= 1'b0;
    endtask

    task automatic read_reg(input logic [7:0] addr, output logic [31:0] data,
                            output logic [1:0] resp);
        @(posedge clk_ifc);
        axil_req.araddr  <= addr;
        axil_req.arvalid <= 1'b1;
        @(negedge clk_ifc);
        while (!axil_rsp.arready) @(negedge clk_ifc);
        @(posedge clk_ifc);
        axil_req.arvalid <= 1'b0;
        @(negedge clk_ifc);
        while (!axil_rsp.rvalid) @(negedge clk_ifc);
        data = axil_rsp.rdata;
        resp = axil_rsp.rresp;
        repeat ($urandom % 3) @(posedge clk_ifc);
        @(posedge clk_ifc);
        axil_req.rready <= 1'b1;
        @(posedge clk_ifc);
        axil_req.rready <= 1'b0;
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
            errors++;
        end
    endtask

    task automatic expect_reg(input logic [7:0] addr, input string name,
                              input logic [31:0] exp);
        logic [31:0] data;
        logic [1:0]  resp;
        read_reg(addr, data, resp);
        check_value({name, " rresp"}, {30'h0, resp}, {30'h0, OKAY});
        check_value(name, data, exp);
    endtask

    task automatic report_test(input string name, input int err_before);
        tests_run++;
        if (errors == err_before) begin
            $display("Test %s: ok", name);
        end else begin
            $display("Test %s: FAILED with %0d errors", name, errors - err_before);
            tests_failed++;
        end
    endtask

    //////////////////////////////////////////////////
    // Traffic runs

    task automatic configure(input logic [31:0] seed, input logic [15:0] count,
                             input logic [5:0] min_len, input logic [5:0] len_mask);
        logic [1:0] resp;
        write_reg(`PKT_REG_SEED, seed, resp);
        check_value("SEED bresp", {30'h0, resp}, {30'h0, OKAY});
        write_reg(`PKT_REG_COUNT, {16'h0, count}, resp);
        check_value("COUNT bresp", {30'h0, resp}, {30'h0, OKAY});
        write_reg(`PKT_REG_LEN, {18'h0, len_mask, 2'b00, min_len}, resp);
        check_value("LEN bresp", {30'h0, resp}, {30'h0, OKAY});
    endtask

    task automatic start_traffic(input logic inject);
        logic [1:0] resp;
        write_reg(`PKT_REG_CTRL, {30'h0, inject, 1'b1}, resp);
        check_value("CTRL bresp", {30'h0, resp}, {30'h0, OKAY});
    endtask

    // Run end is busy low with every packet counted by the sink
    task automatic wait_run_end(input logic [15:0] count);
        logic [31:0] status;
        logic [31:0] good;
        logic [31:0] bad;
        logic [1:0]  resp;
        logic        done;
        done = 1'b0;
        while (!done) begin
            read_reg(`PKT_REG_STATUS, status, resp);
            read_reg(`PKT_REG_GOOD, good, resp);
            read_reg(`PKT_REG_BAD, bad, resp);
            done = !status[0] && (16'(good[15:0] + bad[15:0]) == count);
        end
    endtask

    task automatic finish_traffic(input logic [31:0] seed, input logic [15:0] count,
                                  input logic [5:0] min_len, input logic [5:0] len_mask,
                                  input logic inject);
        logic [15:0] exp_bad;
        wait_run_end(count);
        // An empty first packet has no payload word to corrupt
        exp_bad = (inject && model_len(seed, 16'd0, min_len, len_mask) != 16'd0) ? 16'd1 : 16'd0;
        expect_reg(`PKT_REG_SENT, "SENT", {16'h0, count});
        expect_reg(`PKT_REG_GOOD, "GOOD", {16'h0, 16'(count - exp_bad)});
        expect_reg(`PKT_REG_BAD, "BAD", {16'h0, exp_bad});
    endtask

    task automatic run_traffic(input logic [31:0] seed, input logic [15:0] count,
                               input logic [5:0] min_len, input logic [5:0] len_mask,
                               input logic inject);
        configure(seed, count, min_len, len_mask);
        start_traffic(inject);
        finish_traffic(seed, count, min_len, len_mask, inject);
    endtask

    //////////////////////////////////////////////////
    // Tests

    task automatic registers_rw();
        logic [31:0] val;
        logic [31:0] data;
        logic [1:0]  resp;
        int          err_before;
        err_before = errors;
        expect_reg(`PKT_REG_STATUS, "STATUS", 32'h0);
        expect_reg(`PKT_REG_SENT, "SENT", 32'h0);
        expect_reg(`PKT_REG_GOOD, "GOOD", 32'h0);
        expect_reg(`PKT_REG_BAD, "BAD", 32'h0);
        val = $urandom;
        write_reg(`PKT_REG_SEED, val, resp);
        check_value("SEED bresp", {30'h0, resp}, {30'h0, OKAY});
        expect_reg(`PKT_REG_SEED, "SEED", val);
        val = $urandom;
        write_reg(`PKT_REG_COUNT, val, resp);
        expect_reg(`PKT_REG_COUNT, "COUNT", val & 32'h0000_ffff);
        val = $urandom;
        write_reg(`PKT_REG_LEN, val, resp);
        expect_reg(`PKT_REG_LEN, "LEN", val & 32'h0000_3f3f);
        read_reg(8'(8'h20 + 4 * ($urandom % 8)), data, resp);
        check_value("unmapped rresp", {30'h0, resp}, {30'h0, SLVERR});
        write_reg(`PKT_REG_SENT, $urandom, resp);
        check_value("SENT bresp", {30'h0, resp}, {30'h0, SLVERR});
        report_test("register access", err_before);
    endtask

    task automatic clean_traffic();
        int err_before;
        err_before = errors;
        run_traffic($urandom, 16'(8 + $urandom % 13), 6'($urandom), 6'($urandom), 1'b0);
        report_test("clean run", err_before);
    endtask

    task automatic back_pressure_traffic();
        int err_before;
        err_before = errors;
        run_traffic($urandom, 16'(8 + $urandom % 13), 6'h3f, 6'h3f, 1'b0);
        report_test("back-pressure", err_before);
    endtask

    task automatic inject_error_packet();
        int err_before;
        err_before = errors;
        run_traffic($urandom, 16'(8 + $urandom % 13), 6'(1 + $urandom % 63), 6'($urandom),
                    1'b1);
        report_test("error inject", err_before);
    endtask

    task automatic busy_and_restart();
        logic [31:0] seed;
        logic [15:0] count;
        logic [31:0] sent_before;
        logic [31:0] sent_after;
        logic [1:0]  resp;
        int          err_before;
        err_before = errors;
        seed  = $urandom;
        count = 16'(8 + $urandom % 13);
        configure(seed, count, 6'd32, 6'd31);
        start_traffic(1'b0);
        expect_reg(`PKT_REG_STATUS, "STATUS", 32'h1);
        // First packet out, so a restart would show as SENT back at zero
        sent_before = 32'h0;
        while (sent_before == 32'h0) begin
            read_reg(`PKT_REG_SENT, sent_before, resp);
        end
        // Dropped while busy
        start_traffic(1'b0);
        read_reg(`PKT_REG_SENT, sent_after, resp);
        if (sent_after < sent_before) begin
            $display("Mismatch SENT after second start: got 0x%h, expected at least 0x%h",
                     sent_after, sent_before);
            errors++;
        end
        finish_traffic(seed, count, 6'd32, 6'd31, 1'b0);
        run_traffic($urandom, count, 6'($urandom), 6'($urandom), 1'b0);
        report_test("busy and restart", err_before);
    endtask

    //////////////////////////////////////////////////
    // Main sequence

    initial begin
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        axil_req     = '0;
        rst_n        = 1'b0;
        void'($urandom(32'h8151_bf16));
        repeat (5) @(posedge clk_ifc);
        rst_n <= 1'b1;
        registers_rw();
        clean_traffic();
        back_pressure_traffic();
        inject_error_packet();
        busy_and_restart();
        $display("Tests run: %0d, failed: %0d, errors: %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
